// ==== src/ldpc_pkg.sv ====
package ldpc_pkg;

    typedef logic [8:0]  lift_t;     // lifting size z
    typedef logic [11:0] bitpos_t;   // circular buffer bit index
    typedef logic [11:0] ncb_t;      // circular buffer length
    typedef logic [16:0] outlen_t;   // output length g
    typedef logic [14:0] k0_t;       // factor times z
    typedef logic [1:0]  rv_t;
    typedef logic [1:0]  proc_t;
    typedef logic        bg_t;       // 0 = bg1, 1 = bg2
    typedef logic [31:0] word_t;
    typedef logic [5:0]  factor_t;

    localparam int WORD_BITS = 32;
    localparam ncb_t MAX_NCB = 12'd2048;   // one process buffer, 64 words

    // k0 factor per rv, standard ordering
    localparam factor_t BG1_FACTORS [4] = '{6'd0, 6'd17, 6'd33, 6'd56};
    localparam factor_t BG2_FACTORS [4] = '{6'd0, 6'd13, 6'd25, 6'd43};

    typedef struct packed {
        bg_t     bg;
        rv_t     rv;
        proc_t   proc;
        lift_t   z;
        ncb_t    ncb;
        outlen_t g;
    } rm_cfg_t;

endpackage

// ==== src/wb_pkg.sv ====
package wb_pkg;

    typedef logic [8:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    localparam wb_adr_t REG_CTRL   = 9'd0;     // bit 0 starts a run
    localparam wb_adr_t REG_CFG    = 9'd1;     // bg, rv, proc, z
    localparam wb_adr_t REG_NCB    = 9'd2;
    localparam wb_adr_t REG_G      = 9'd3;
    localparam wb_adr_t REG_STATUS = 9'd4;     // busy, err
    localparam wb_adr_t BUF_BASE   = 9'd256;   // start of buffer window

endpackage

// ==== src/wb_regs.sv ====
module wb_regs #(
    parameter int NUM_PROC       = 4,
    parameter int WORDS_PER_PROC = 64
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  wb_pkg::wb_req_t                               wb_req,
    output wb_pkg::wb_rsp_t                               wb_rsp,
    input  logic                                          busy,
    input  logic                                          err,
    output ldpc_pkg::rm_cfg_t                             cfg,
    output logic                                          start,
    output logic                                          buf_we,
    output logic [$clog2(NUM_PROC*WORDS_PER_PROC)-1:0]    buf_waddr,
    output ldpc_pkg::word_t                               buf_wdata
);

    localparam int DEPTH = NUM_PROC * WORDS_PER_PROC;
    localparam int AW    = $clog2(DEPTH);

    logic            ack_q;
    wb_pkg::wb_dat_t rdat_q;
    wb_pkg::wb_dat_t rd_mux;
    wb_pkg::wb_adr_t buf_off;
    logic            req;
    logic            wr_ok;
    logic            in_buf;

    assign req     = wb_req.cyc && wb_req.stb && !ack_q;   // new cycle, not yet acked
    assign wr_ok   = req && wb_req.we && !busy;           // writes dropped while running
    assign buf_off = wb_req.adr - wb_pkg::BUF_BASE;
    assign in_buf  = (wb_req.adr >= wb_pkg::BUF_BASE) && (int'(buf_off) < DEPTH);

    always_comb
    begin
        case (wb_req.adr)
            wb_pkg::REG_CFG:    rd_mux = wb_pkg::wb_dat_t'({cfg.z, cfg.proc, cfg.rv, cfg.bg});
            wb_pkg::REG_NCB:    rd_mux = wb_pkg::wb_dat_t'(cfg.ncb);
            wb_pkg::REG_G:      rd_mux = wb_pkg::wb_dat_t'(cfg.g);
            wb_pkg::REG_STATUS: rd_mux = wb_pkg::wb_dat_t'({err, busy});
            default:            rd_mux = '0;   // ctrl, buffer window, holes
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ack_q  <= 1'b0;
            rdat_q <= '0;
            start  <= 1'b0;
            buf_we <= 1'b0;
            cfg    <= '0;
        end
        else
        begin
            ack_q  <= req;
            rdat_q <= (req && !wb_req.we) ? rd_mux : '0;
            start  <= wr_ok && (wb_req.adr == wb_pkg::REG_CTRL) && wb_req.dat[0];   // with ack
            buf_we <= wr_ok && in_buf;
            if (wr_ok)
            begin
                case (wb_req.adr)
                    wb_pkg::REG_CFG:
                    begin
                        cfg.bg   <= wb_req.dat[0];
                        cfg.rv   <= wb_req.dat[2:1];
                        cfg.proc <= wb_req.dat[4:3];
                        cfg.z    <= wb_req.dat[13:5];
                    end
                    wb_pkg::REG_NCB: cfg.ncb <= wb_req.dat[11:0];
                    wb_pkg::REG_G:   cfg.g   <= wb_req.dat[16:0];
                    default:         ;
                endcase
            end
        end
    end

    // write payload, qualified by buf_we
    always_ff @(posedge clk)
    begin
        buf_waddr <= buf_off[AW-1:0];
        buf_wdata <= wb_req.dat;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

endmodule

// ==== src/harq_buffer.sv ====
module harq_buffer #(
    parameter int NUM_PROC       = 4,
    parameter int WORDS_PER_PROC = 64
) (
    input  logic                                       clk,
    input  logic                                       we,
    input  logic [$clog2(NUM_PROC*WORDS_PER_PROC)-1:0] waddr,
    input  ldpc_pkg::word_t                            wdata,
    input  logic [$clog2(NUM_PROC*WORDS_PER_PROC)-1:0] raddr,
    output ldpc_pkg::word_t                            rdata
);

    localparam int DEPTH = NUM_PROC * WORDS_PER_PROC;

    // process p owns words p*WORDS_PER_PROC and up
    ldpc_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// ==== src/rm_ctrl.sv ====
module rm_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  ldpc_pkg::rm_cfg_t   cfg,
    output logic                busy,
    output logic                err,
    output logic                cnt_load,
    output logic                cnt_step,
    output ldpc_pkg::bitpos_t   cnt_start,
    output ldpc_pkg::outlen_t   cnt_count,
    input  logic                cnt_last,
    output logic                ser_take_hdr,
    output logic                ser_hdr_bit,
    output logic                ser_take_data,
    output logic                ser_start,
    input  logic                ser_done
);

    typedef enum logic [2:0] {IDLE, CHECK, HEADER0, HEADER1, STREAM, FINISH} state_t;

    state_t              state;
    logic                req_pend;   // a bit is handed to the serializer, not yet sent
    ldpc_pkg::factor_t   factor;
    ldpc_pkg::k0_t       k0;
    logic                cfg_bad;

    assign factor = cfg.bg ? ldpc_pkg::BG2_FACTORS[cfg.rv] : ldpc_pkg::BG1_FACTORS[cfg.rv];
    assign k0     = ldpc_pkg::k0_t'(factor) * ldpc_pkg::k0_t'(cfg.z);

    assign cfg_bad = (cfg.ncb == '0) || (cfg.ncb > ldpc_pkg::MAX_NCB)
                  || (k0 >= ldpc_pkg::k0_t'(cfg.ncb)) || (cfg.g < ldpc_pkg::outlen_t'(2));

    assign busy          = (state != IDLE);
    assign cnt_load      = (state == CHECK) && !cfg_bad;
    assign ser_start     = cnt_load;
    assign cnt_start     = ldpc_pkg::bitpos_t'(k0);   // k0 < ncb here
    assign cnt_count     = cfg.g - ldpc_pkg::outlen_t'(2);   // data bits after rv header
    assign ser_take_hdr  = ((state == HEADER0) || (state == HEADER1)) && !req_pend;
    assign ser_hdr_bit   = (state == HEADER1) ? cfg.rv[1] : cfg.rv[0];   // lsb first
    assign ser_take_data = (state == STREAM) && !req_pend;
    assign cnt_step      = (state == STREAM) && ser_done;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state    <= IDLE;
            err      <= 1'b0;
            req_pend <= 1'b0;
        end
        else
        begin
            if (ser_done)
                req_pend <= 1'b0;
            else if (ser_take_hdr || ser_take_data)
                req_pend <= 1'b1;

            case (state)
                IDLE:
                    if (start)
                        state <= CHECK;
                CHECK:
                begin
                    err   <= cfg_bad;   // refused start flags, good start clears
                    state <= cfg_bad ? IDLE : HEADER0;
                end
                HEADER0:
                    if (ser_done)
                        state <= HEADER1;
                HEADER1:
                    if (ser_done)
                        state <= (cfg.g == ldpc_pkg::outlen_t'(2)) ? FINISH : STREAM;
                STREAM:
                    if (ser_done && cnt_last)
                        state <= FINISH;
                FINISH:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/bit_counter.sv ====
module bit_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                step,
    input  ldpc_pkg::bitpos_t   start_pos,
    input  ldpc_pkg::ncb_t      ncb,
    input  ldpc_pkg::outlen_t   count,
    output ldpc_pkg::bitpos_t   pos,
    output logic                last
);

    ldpc_pkg::outlen_t remaining;   // data bits still to send
    logic              at_end;

    // bit ncb-1 is the last one of the circular buffer
    assign at_end = (pos == ldpc_pkg::bitpos_t'(ncb - ldpc_pkg::ncb_t'(1)));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pos       <= '0;
            remaining <= '0;
        end
        else if (load)
        begin
            pos       <= start_pos;   // k0
            remaining <= count;
        end
        else if (step)
        begin
            if (at_end)
                pos <= '0;   // wrap, repetition
            else
                pos <= pos + ldpc_pkg::bitpos_t'(1);
            remaining <= remaining - ldpc_pkg::outlen_t'(1);
        end
    end

    assign last = (remaining == ldpc_pkg::outlen_t'(1));

endmodule

// ==== src/bit_serializer.sv ====
module bit_serializer #(
    parameter int WORDS_PER_PROC = 64
) (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic                                                        run_start,
    input  logic                                                        take_hdr,
    input  logic                                                        take_data,
    input  logic                                                        hdr_bit,
    input  ldpc_pkg::proc_t                                             proc,
    input  ldpc_pkg::bitpos_t                                           pos,
    output logic [$bits(ldpc_pkg::proc_t)+$clog2(WORDS_PER_PROC)-1:0]   raddr,
    input  ldpc_pkg::word_t                                             rdata,
    output logic                                                        out_bit,
    output logic                                                        out_valid,
    input  logic                                                        out_ready,
    output logic                                                        done
);

    localparam int WIW = $clog2(WORDS_PER_PROC);
    localparam int SW  = $clog2(ldpc_pkg::WORD_BITS);

    typedef enum logic [1:0] {SER_IDLE, SER_FETCH, SER_LOAD} ser_state_t;

    ser_state_t       state;
    logic             word_ok;     // held_word is valid for this run
    logic [WIW-1:0]   held_idx;
    ldpc_pkg::word_t  held_word;
    logic [WIW-1:0]   word_idx;
    logic [SW-1:0]    bit_sel;
    logic             hit;
    logic             miss;

    assign word_idx = WIW'(pos >> SW);
    assign bit_sel  = pos[SW-1:0];   // lsb numbering
    assign hit      = word_ok && (held_idx == word_idx);
    assign miss     = (state == SER_IDLE) && take_data && !hit;
    assign done     = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= SER_IDLE;
            word_ok   <= 1'b0;
            out_bit   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (done)
                out_valid <= 1'b0;
            case (state)
                SER_IDLE:
                    if (take_hdr)
                    begin
                        out_bit   <= hdr_bit;
                        out_valid <= 1'b1;
                    end
                    else if (take_data && hit)
                    begin
                        out_bit   <= held_word[bit_sel];
                        out_valid <= 1'b1;
                    end
                    else if (miss)
                        state <= SER_FETCH;
                SER_FETCH:
                    state <= SER_LOAD;   // memory samples raddr
                SER_LOAD:
                begin
                    out_bit   <= rdata[bit_sel];
                    out_valid <= 1'b1;
                    word_ok   <= 1'b1;
                    state     <= SER_IDLE;
                end
                default:
                    state <= SER_IDLE;
            endcase
            if (run_start)
                word_ok <= 1'b0;   // new run may use another process
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss)
            raddr <= {proc, word_idx};
        if (state == SER_LOAD)
        begin
            held_word <= rdata;
            held_idx  <= word_idx;
        end
    end

endmodule

// ==== src/rate_matcher_top.sv ====
module rate_matcher_top #(
    parameter int NUM_PROC       = 4,
    parameter int WORDS_PER_PROC = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    output logic            out_bit,
    output logic            out_valid,
    input  logic            out_ready
);

    localparam int AW = $clog2(NUM_PROC * WORDS_PER_PROC);

    ldpc_pkg::rm_cfg_t  cfg;
    logic               busy;
    logic               err;
    logic               start;
    logic               buf_we;
    logic [AW-1:0]      buf_waddr;
    logic [AW-1:0]      buf_raddr;
    ldpc_pkg::word_t    buf_wdata;
    ldpc_pkg::word_t    buf_rdata;
    logic               cnt_load;
    logic               cnt_step;
    logic               cnt_last;
    ldpc_pkg::bitpos_t  cnt_start;
    ldpc_pkg::bitpos_t  cnt_pos;
    ldpc_pkg::outlen_t  cnt_count;
    logic               ser_take_hdr;
    logic               ser_hdr_bit;
    logic               ser_take_data;
    logic               ser_start;
    logic               ser_done;

    wb_regs #(
        .NUM_PROC       (NUM_PROC),
        .WORDS_PER_PROC (WORDS_PER_PROC)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .busy      (busy),
        .err       (err),
        .cfg       (cfg),
        .start     (start),
        .buf_we    (buf_we),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata)
    );

    harq_buffer #(
        .NUM_PROC       (NUM_PROC),
        .WORDS_PER_PROC (WORDS_PER_PROC)
    ) u_buf (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .raddr (buf_raddr),
        .rdata (buf_rdata)
    );

    rm_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .cfg           (cfg),
        .busy          (busy),
        .err           (err),
        .cnt_load      (cnt_load),
        .cnt_step      (cnt_step),
        .cnt_start     (cnt_start),
        .cnt_count     (cnt_count),
        .cnt_last      (cnt_last),
        .ser_take_hdr  (ser_take_hdr),
        .ser_hdr_bit   (ser_hdr_bit),
        .ser_take_data (ser_take_data),
        .ser_start     (ser_start),
        .ser_done      (ser_done)
    );

    bit_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .load      (cnt_load),
        .step      (cnt_step),
        .start_pos (cnt_start),
        .ncb       (cfg.ncb),
        .count     (cnt_count),
        .pos       (cnt_pos),
        .last      (cnt_last)
    );

    bit_serializer #(
        .WORDS_PER_PROC (WORDS_PER_PROC)
    ) u_ser (
        .clk       (clk),
        .rst       (rst),
        .run_start (ser_start),
        .take_hdr  (ser_take_hdr),
        .take_data (ser_take_data),
        .hdr_bit   (ser_hdr_bit),
        .proc      (cfg.proc),
        .pos       (cnt_pos),
        .raddr     (buf_raddr),
        .rdata     (buf_rdata),
        .out_bit   (out_bit),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (ser_done)
    );

endmodule

// ==== sim/rate_matcher_chk.sv ====
module rate_matcher_chk (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_rsp_t wb_rsp,
    input  logic            busy,
    input  logic            out_bit,
    input  logic            out_valid,
    input  logic            out_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // classic cycle, ack is a single pulse
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("wishbone ack held longer than one cycle");

    // stalled bit must hold until taken
    stream_hold: assert property (
        @(posedge clk) disable iff (!rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_bit))
    ) else $error("stream output changed under back-pressure");

    valid_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst)
        !busy |-> !out_valid
    ) else $error("out_valid high while the rate matcher is idle");

endmodule

// ==== sim/tb_rate_matcher.sv ====
module tb_rate_matcher;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS     = 64;
    localparam int NUM_WORDS = 4 * WORDS;
    localparam int TIMEOUT_CYCLES = 4 * (600 + 1000 + 500 + 900 + 1200) + 2000;   // sum of g
    localparam int BG1_FACTOR [4] = '{0, 17, 33, 56};
    localparam int BG2_FACTOR [4] = '{0, 13, 25, 43};

    logic            clk;
    logic            rst;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_rsp_t wb_rsp;
    logic            out_bit;
    logic            out_valid;
    logic            out_ready;

    logic [31:0] buf_model [NUM_WORDS];   // host copy of the harq memory
    int          bit_errors;
    int          other_errors;
    int          cycle_count;
    int          rx_idx;
    int          exp_len;
    int          valid_cycles;
    logic        random_ready;
    int          run_bg;
    int          run_rv;
    int          run_proc;
    int          run_z;
    int          run_ncb;

    rate_matcher_top #(
        .NUM_PROC       (4),
        .WORDS_PER_PROC (WORDS)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .out_bit   (out_bit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind rate_matcher_top rate_matcher_chk chk0 (
        .clk       (clk),
        .rst       (rst),
        .wb_rsp    (wb_rsp),
        .busy      (busy),
        .out_bit   (out_bit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        #1;
        out_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;   // about 75% ready
    end

    // rv header lsb first then circular data from k0
    function automatic logic expected_bit(input int bg, input int rv, input int proc,
                                          input int z, input int ncb, input int idx);
        int k0;
        int pos;
        logic [31:0] w;
        if (idx < 2)
            return rv[idx];
        k0  = (bg != 0 ? BG2_FACTOR[rv] : BG1_FACTOR[rv]) * z;
        pos = (k0 + idx - 2) % ncb;
        w   = buf_model[proc * WORDS + pos / 32];
        return w[pos % 32];
    endfunction

    always @(negedge clk)
    begin
        if (rst && out_valid)
            valid_cycles++;
        if (rst && out_valid && out_ready)
        begin
            if (rx_idx >= exp_len)
            begin
                $display("Extra bit received at %0t, the run has only %0d bits", $time, exp_len);
                other_errors++;
            end
            else if (out_bit !== expected_bit(run_bg, run_rv, run_proc, run_z, run_ncb, rx_idx))
            begin
                $display("Fail %0t: bit %0d expected %0b got %0b", $time, rx_idx,
                         expected_bit(run_bg, run_rv, run_proc, run_z, run_ncb, rx_idx), out_bit);
                bit_errors++;
            end
            rx_idx++;
        end
    end

    task automatic wb_cycle(input logic we, input logic [8:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do
        begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);   // hold until ack
        rdat = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [8:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic check_reg(input logic [8:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        wb_cycle(1'b0, adr, '0, rd);
        if (rd !== exp)
        begin
            $display("Fail %0t: register %0d read %h expected %h", $time, adr, rd, exp);
            other_errors++;
        end
    endtask

    task automatic wait_idle(output logic [31:0] st);
        do
            wb_cycle(1'b0, wb_pkg::REG_STATUS, '0, st);
        while (st[0]);   // busy
    endtask

    task automatic set_config(input int bg, input int rv, input int proc, input int z,
                              input int ncb, input int g);
        logic [31:0] cfg_word;
        cfg_word = {18'd0, 9'(z), 2'(proc), 2'(rv), 1'(bg)};
        wb_write(wb_pkg::REG_CFG, cfg_word);
        wb_write(wb_pkg::REG_NCB, 32'(ncb));
        wb_write(wb_pkg::REG_G, 32'(g));
        check_reg(wb_pkg::REG_CFG, cfg_word);
        check_reg(wb_pkg::REG_NCB, 32'(ncb));
        check_reg(wb_pkg::REG_G, 32'(g));
        run_bg   = bg;
        run_rv   = rv;
        run_proc = proc;
        run_z    = z;
        run_ncb  = ncb;
    endtask

    task automatic run_case(input int bg, input int rv, input int proc, input int z,
                            input int ncb, input int g, input logic rnd);
        logic [31:0] st;
        set_config(bg, rv, proc, z, ncb, g);
        rx_idx       = 0;
        exp_len      = g;
        random_ready = rnd;
        wb_write(wb_pkg::REG_CTRL, 32'd1);
        wb_cycle(1'b0, wb_pkg::REG_STATUS, '0, st);
        if (!st[0])
        begin
            $display("Fail %0t: status shows no busy during a run", $time);
            other_errors++;
        end
        wait_idle(st);
        if (rx_idx != g)
        begin
            $display("Fail %0t: run ended after %0d bits, expected %0d", $time, rx_idx, g);
            other_errors++;
        end
        if (st[1])
        begin
            $display("Fail %0t: error flag set after a valid start", $time);
            other_errors++;
        end
        random_ready = 1'b0;
    endtask

    task automatic refused_case(input int bg, input int rv, input int z, input int ncb,
                                input int g);
        logic [31:0] st;
        set_config(bg, rv, 0, z, ncb, g);
        rx_idx       = 0;
        exp_len      = 0;   // no bit may leave
        valid_cycles = 0;
        wb_write(wb_pkg::REG_CTRL, 32'd1);
        wait_idle(st);
        if (st[1:0] !== 2'b10)
        begin
            $display("Fail %0t: status %b after refused start, expected 10", $time, st[1:0]);
            other_errors++;
        end
        if (valid_cycles != 0)
        begin
            $display("Refused start still raised out_valid for %0d cycles", valid_cycles);
            other_errors++;
        end
    endtask

    initial
    begin
        logic [31:0] w;
        clk          = 1'b0;
        rst          = 1'b0;
        wb_req       = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        bit_errors   = 0;
        other_errors = 0;
        cycle_count  = 0;
        rx_idx       = 0;
        exp_len      = 0;
        valid_cycles = 0;
        void'($urandom(32'hf0d5_52ff));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        if (wb_rsp.ack !== 1'b0 || out_valid !== 1'b0)
        begin
            $display("Fail %0t: ack or out_valid high after reset", $time);
            other_errors++;
        end
        check_reg(wb_pkg::REG_STATUS, 32'd0);

        for (int i = 0; i < NUM_WORDS; i++)
        begin
            w            = $urandom;
            buf_model[i] = w;
            wb_write(9'(int'(wb_pkg::BUF_BASE) + i), w);
        end
        check_reg(wb_pkg::BUF_BASE, 32'd0);   // window is write only

        run_case(0, 0, 0, 20, 1500, 600, 1'b0);    // puncturing
        run_case(1, 2, 2, 16, 700, 1000, 1'b0);    // k0 400 with repetition
        run_case(0, 1, 1, 24, 2048, 500, 1'b0);
        run_case(1, 3, 3, 10, 1200, 900, 1'b1);    // back-pressure
        refused_case(0, 3, 20, 1000, 300);         // k0 1120 past ncb
        run_case(0, 2, 1, 30, 1800, 1200, 1'b1);   // clears err and wraps

        $display("Closing counts: %0d bit errors, %0d other errors", bit_errors, other_errors);
        if (bit_errors == 0 && other_errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== rate_matcher_top.f ====
src/ldpc_pkg.sv
src/wb_pkg.sv
src/wb_regs.sv
src/harq_buffer.sv
src/rm_ctrl.sv
src/bit_counter.sv
src/bit_serializer.sv
src/rate_matcher_top.sv
sim/rate_matcher_chk.sv
sim/tb_rate_matcher.sv

// ==== Bender.yml ====
package:
  name: rate_matcher

sources:
  - src/ldpc_pkg.sv
  - src/wb_pkg.sv
  - src/wb_regs.sv
  - src/harq_buffer.sv
  - src/rm_ctrl.sv
  - src/bit_counter.sv
  - src/bit_serializer.sv
  - src/rate_matcher_top.sv
  - target: simulation
    files:
      - sim/rate_matcher_chk.sv
      - sim/tb_rate_matcher.sv
